/* branch_unit.f */
+incdir+common
common/isa_pkg.sv
common/branch_pkg.sv
predictor/branch_predictor.sv
verilog/branch_resolver.sv
verilog/branch_control.sv
verilog/branch_unit.sv
tb/branch_unit_assertions.sv
tb/tb_branch_unit.sv

/* common/branch_defines.svh */
`ifndef BRANCH_DEFINES_SVH
`define BRANCH_DEFINES_SVH

// --------------------
// datapath widths

// data and address width
`define WORD_SIZE 16

// --------------------
// branch target buffer geometry

// low pc bits select the entry
`define BTB_INDEX_BITS 4
`define BTB_ENTRIES (1 << `BTB_INDEX_BITS)
// upper pc bits kept as tag
`define BTB_TAG_BITS 12

// --------------------
// prediction counters

`define COUNTER_BITS 2
// entry predicts taken at or above this
`define TAKEN_THRESHOLD 2
// weakly taken on allocation
`define COUNTER_INIT 2

`endif

/* common/branch_pkg.sv */
`include "branch_defines.svh"

package branch_pkg;

        // --------------------
        // handshake controller states
        typedef enum logic [1:0] {
                ST_IDLE = 2'd0,
                ST_EVAL = 2'd1,
                ST_ACK  = 2'd2
        } ctrl_state_t;

        // --------------------
        // buffer entry fields

        // pc bits above the index
        typedef logic [`BTB_TAG_BITS-1:0] btb_tag_t;

        // entry select
        typedef logic [`BTB_INDEX_BITS-1:0] btb_index_t;

        // saturating taken counter
        typedef logic [`COUNTER_BITS-1:0] counter_t;

endpackage

/* common/isa_pkg.sv */
package isa_pkg;

        // --------------------
        // opcodes seen by the branch unit
        // every other value is a non-branch
        typedef enum logic [3:0] {
                BNE = 4'd0,
                BEQ = 4'd1,
                BGZ = 4'd2,
                BLZ = 4'd3,
                JMP = 4'd9
        } opcode_t;

        // signed compare of first operand against second
        typedef enum logic [1:0] {
                CMP_BIG   = 2'd0,
                CMP_SAME  = 2'd1,
                CMP_SMALL = 2'd2
        } compare_t;

        // --------------------
        // instruction fields
        localparam int OPCODE_MSB = 15;
        localparam int OPCODE_LSB = 12;
        // branch offset, bits 7..0
        localparam int IMM8_MSB = 7;
        // jump target, bits 11..0
        localparam int IMM12_MSB = 11;

endpackage

/* predictor/branch_predictor.sv */
`timescale 1ns/1ns
`include "branch_defines.svh"

module branch_predictor (
        input  logic                  clk,
        input  logic                  reset_n,
        input  logic                  i_start,
        input  logic [`WORD_SIZE-1:0] i_pc,
        input  logic                  i_update,
        input  logic                  i_taken,
        input  logic [`WORD_SIZE-1:0] i_target,
        output logic [`WORD_SIZE-1:0] o_pred_pc
);
        import branch_pkg::*;

        // --------------------
        // buffer storage
        logic [`BTB_ENTRIES-1:0] valid;
        btb_tag_t                tags     [`BTB_ENTRIES];
        logic [`WORD_SIZE-1:0]   targets  [`BTB_ENTRIES];
        counter_t                counters [`BTB_ENTRIES];

        // lookup side
        btb_index_t lookup_idx;
        btb_tag_t   lookup_tag;
        logic       lookup_hit;
        logic       predict_taken;

        // entry held for the later update
        btb_index_t upd_idx;
        btb_tag_t   upd_tag;
        logic       upd_hit;

        assign lookup_idx = i_pc[`BTB_INDEX_BITS-1:0];
        assign lookup_tag = i_pc[`WORD_SIZE-1:`BTB_INDEX_BITS];
        assign lookup_hit = valid[lookup_idx] && (tags[lookup_idx] == lookup_tag);
        // counter only matters on a tag hit
        assign predict_taken = lookup_hit &&
                               (counters[lookup_idx] >= counter_t'(`TAKEN_THRESHOLD));

        // --------------------
        // lookup, one cycle after start
        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        o_pred_pc <= '0;
                        upd_idx   <= '0;
                        upd_tag   <= '0;
                        upd_hit   <= 1'b0;
                end else if (i_start) begin
                        o_pred_pc <= predict_taken ? targets[lookup_idx] : i_pc + 1'b1;
                        upd_idx   <= lookup_idx;
                        upd_tag   <= lookup_tag;
                        upd_hit   <= lookup_hit;
                end
        end

        // --------------------
        // update from resolved outcome

        // allocate on a taken miss
        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        valid <= '0;
                end else if (i_update && i_taken && !upd_hit) begin
                        valid[upd_idx] <= 1'b1;
                end
        end

        always_ff @(posedge clk) begin
                if (i_update) begin
                        if (upd_hit) begin
                                if (i_taken) begin
                                        // strengthen, saturate at max
                                        if (counters[upd_idx] != '1)
                                                counters[upd_idx] <= counters[upd_idx] + 1'b1;
                                        targets[upd_idx] <= i_target;
                                end else if (counters[upd_idx] != '0) begin
                                        counters[upd_idx] <= counters[upd_idx] - 1'b1;
                                end
                        end else if (i_taken) begin
                                // new or aliased entry, replace it
                                tags[upd_idx]     <= upd_tag;
                                targets[upd_idx]  <= i_target;
                                counters[upd_idx] <= counter_t'(`COUNTER_INIT);
                        end
                        // not taken on a miss leaves the entry alone
                end
        end

endmodule

/* tb/branch_unit_assertions.sv */
`timescale 1ns/1ns
`include "branch_defines.svh"

module branch_unit_assertions (
        input logic                  clk,
        input logic                  reset_n,
        input logic                  i_req,
        input logic                  o_ack,
        input logic [`WORD_SIZE-1:0] o_num_branch,
        input logic [`WORD_SIZE-1:0] o_num_miss
);

        // --------------------
        // four-phase ordering
        ack_rise_needs_req: assert property (@(posedge clk) disable iff (!reset_n)
                $rose(o_ack) |-> $past(i_req))
                else $error("o_ack rose while i_req was low");

        ack_fall_after_req_low: assert property (@(posedge clk) disable iff (!reset_n)
                $fell(o_ack) |-> !$past(i_req))
                else $error("o_ack fell before i_req was dropped");

        // --------------------
        // statistics
        miss_within_branches: assert property (@(posedge clk) disable iff (!reset_n)
                o_num_miss <= o_num_branch)
                else $error("miss count exceeds branch count");

        counters_monotonic: assert property (@(posedge clk) disable iff (!reset_n)
                $past(reset_n) |-> (o_num_branch >= $past(o_num_branch)) &&
                                   (o_num_miss >= $past(o_num_miss)))
                else $error("a branch counter decreased");

endmodule

bind branch_unit branch_unit_assertions u_branch_unit_assertions (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_req        (i_req),
        .o_ack        (o_ack),
        .o_num_branch (o_num_branch),
        .o_num_miss   (o_num_miss)
);

/* tb/tb_branch_unit.sv */
`timescale 1ns/1ns
`include "branch_defines.svh"

module tb_branch_unit;
        import isa_pkg::*;

        localparam int NUM_TRANS      = 300;
        localparam int TIMEOUT_CYCLES = NUM_TRANS * 8 + 20;
        localparam int COUNTER_MAX    = (1 << `COUNTER_BITS) - 1;

        logic                  clk;
        logic                  reset_n;
        logic                  i_req;
        logic [`WORD_SIZE-1:0] i_pc;
        logic [`WORD_SIZE-1:0] i_instr;
        logic [`WORD_SIZE-1:0] i_op_a;
        logic [`WORD_SIZE-1:0] i_op_b;
        logic                  o_ack;
        logic [`WORD_SIZE-1:0] o_next_pc;
        logic                  o_mispredict;
        logic [`WORD_SIZE-1:0] o_num_branch;
        logic [`WORD_SIZE-1:0] o_num_miss;

        // --------------------
        // reference model state
        logic                     m_valid   [`BTB_ENTRIES];
        logic [`BTB_TAG_BITS-1:0] m_tag     [`BTB_ENTRIES];
        logic [`WORD_SIZE-1:0]    m_target  [`BTB_ENTRIES];
        int                       m_counter [`BTB_ENTRIES];
        int                       m_branches;
        int                       m_misses;
        logic [`WORD_SIZE-1:0]    exp_next_pc;
        logic                     exp_mispredict;

        logic [31:0] rand_state;
        int          cycle_count = 0;
        int          error_count = 0;

        branch_unit i_branch_unit (.*);

        initial begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        always @(posedge clk) begin
                cycle_count = cycle_count + 1;
                if (cycle_count >= TIMEOUT_CYCLES) begin
                        $display("timeout: transactions did not finish in %0d cycles",
                                 TIMEOUT_CYCLES);
                        $display("TEST FAILED");
                        $fatal(1, "run stopped by cycle limit");
                end
        end

        // lcg, upper bits are the better ones
        function automatic logic [31:0] next_rand();
                rand_state = rand_state * 32'd1103515245 + 32'd12345;
                return rand_state >> 16;
        endfunction

        // 0x0013 and 0x0a53 share index 3
        function automatic logic [15:0] pool_pc(input int sel);
                case (sel)
                        0: return 16'h0010;
                        1: return 16'h0013;
                        2: return 16'h0A53;
                        3: return 16'h0125;
                        4: return 16'h2107;
                        5: return 16'h3FF9;
                        6: return 16'h0B3C;
                        default: return 16'hF00E;
                endcase
        endfunction

        function automatic logic [3:0] pick_opcode(input int sel);
                case (sel)
                        0: return BNE;
                        1: return BEQ;
                        2: return BGZ;
                        3: return BLZ;
                        4: return JMP;
                        // not a branch
                        default: return 4'd5;
                endcase
        endfunction

        task automatic check_value(input string sig_name, input logic [31:0] got,
                                   input logic [31:0] expected);
                if (got !== expected) begin
                        error_count++;
                        $display("mismatch at %0t ns: %s got %0h expected %0h",
                                 $time, sig_name, got, expected);
                        $display("TEST FAILED");
                        $fatal(1, "stopped at first error");
                end
        endtask

        // --------------------
        // resolve one branch and train the model buffer
        task automatic model_transaction(input logic [15:0] pc, input logic [15:0] instr,
                                         input logic [15:0] a, input logic [15:0] b);
                logic [3:0]               opc;
                logic                     is_branch;
                logic                     taken;
                logic                     hit;
                logic [15:0]              target;
                logic [15:0]              pred;
                logic [`BTB_TAG_BITS-1:0] tag;
                int                       idx;
                opc       = instr[OPCODE_MSB:OPCODE_LSB];
                idx       = pc[`BTB_INDEX_BITS-1:0];
                tag       = pc[15:`BTB_INDEX_BITS];
                is_branch = 1'b1;
                taken     = 1'b0;
                target    = pc + 16'd1 + {{8{instr[IMM8_MSB]}}, instr[IMM8_MSB:0]};
                case (opc)
                        BNE: taken = (a != b);
                        BEQ: taken = (a == b);
                        BGZ: taken = ($signed(a) > 16'sd0);
                        BLZ: taken = ($signed(a) < 16'sd0);
                        JMP: begin
                                taken  = 1'b1;
                                target = {pc[15:12], instr[IMM12_MSB:0]};
                        end
                        default: is_branch = 1'b0;
                endcase
                exp_next_pc = taken ? target : pc + 16'd1;
                hit = m_valid[idx] && (m_tag[idx] == tag);
                if (hit && m_counter[idx] >= `TAKEN_THRESHOLD)
                        pred = m_target[idx];
                else
                        pred = pc + 16'd1;
                exp_mispredict = is_branch && (pred != exp_next_pc);
                if (is_branch) begin
                        m_branches++;
                        if (exp_mispredict)
                                m_misses++;
                        if (hit && taken) begin
                                if (m_counter[idx] < COUNTER_MAX)
                                        m_counter[idx]++;
                                m_target[idx] = exp_next_pc;
                        end else if (hit) begin
                                if (m_counter[idx] > 0)
                                        m_counter[idx]--;
                        end else if (taken) begin
                                m_valid[idx]   = 1'b1;
                                m_tag[idx]     = tag;
                                m_target[idx]  = exp_next_pc;
                                m_counter[idx] = `COUNTER_INIT;
                        end
                end
        endtask

        task automatic check_results();
                check_value("o_ack", o_ack, 1);
                check_value("o_next_pc", o_next_pc, exp_next_pc);
                check_value("o_mispredict", o_mispredict, exp_mispredict);
                check_value("o_num_branch", o_num_branch, m_branches);
                check_value("o_num_miss", o_num_miss, m_misses);
        endtask

        // --------------------
        // stimulus, driven on the falling edge
        initial begin
                logic [31:0] r;
                logic [15:0] pc;
                logic [15:0] instr;
                logic [15:0] a;
                logic [15:0] b;
                int          edges;
                int          hold;
                rand_state = 32'd85;
                reset_n    = 1'b0;
                i_req      = 1'b0;
                i_pc       = '0;
                i_instr    = '0;
                i_op_a     = '0;
                i_op_b     = '0;
                m_branches = 0;
                m_misses   = 0;
                for (int i = 0; i < `BTB_ENTRIES; i++)
                        m_valid[i] = 1'b0;
                repeat (4) @(negedge clk);
                reset_n = 1'b1;
                @(negedge clk);
                check_value("o_ack", o_ack, 0);
                check_value("o_mispredict", o_mispredict, 0);
                check_value("o_num_branch", o_num_branch, 0);
                check_value("o_num_miss", o_num_miss, 0);

                for (int t = 0; t < NUM_TRANS; t++) begin
                        pc    = pool_pc(int'(next_rand() % 8));
                        r     = next_rand();
                        instr[OPCODE_MSB:OPCODE_LSB] = pick_opcode(int'(r % 6));
                        r     = next_rand();
                        instr[IMM12_MSB:0] = r[11:0];
                        r     = next_rand();
                        a     = {{13{r[2]}}, r[2:0]};
                        // equal operands now and then for beq and bne
                        b     = r[6] ? a : {{13{r[5]}}, r[5:3]};
                        model_transaction(pc, instr, a, b);
                        i_pc    = pc;
                        i_instr = instr;
                        i_op_a  = a;
                        i_op_b  = b;
                        i_req   = 1'b1;
                        edges   = 0;
                        while (o_ack !== 1'b1) begin
                                @(negedge clk);
                                edges++;
                        end
                        // ack rises two edges after i_req is first sampled
                        // and shows up at the third falling edge
                        check_value("ack latency", edges, 3);
                        check_results();
                        // back-pressure, results must hold
                        hold = int'(next_rand() % 4);
                        repeat (hold) begin
                                @(negedge clk);
                                check_results();
                        end
                        i_req = 1'b0;
                        @(negedge clk);
                        check_value("o_ack", o_ack, 0);
                end

                if (error_count == 0) begin
                        $display("TEST OK");
                        $finish;
                end else begin
                        $display("TEST FAILED");
                        $fatal(1, "checks failed");
                end
        end

endmodule

/* verilog/branch_control.sv */
`timescale 1ns/1ns
`include "branch_defines.svh"

module branch_control (
        input  logic                  clk,
        input  logic                  reset_n,
        input  logic                  i_req,
        input  logic [`WORD_SIZE-1:0] i_pred_pc,
        input  logic                  i_is_branch,
        input  logic                  i_taken,
        input  logic [`WORD_SIZE-1:0] i_actual_pc,
        output logic                  o_start,
        output logic                  o_update,
        output logic                  o_ack,
        output logic [`WORD_SIZE-1:0] o_next_pc,
        output logic                  o_mispredict,
        output logic [`WORD_SIZE-1:0] o_num_branch,
        output logic [`WORD_SIZE-1:0] o_num_miss
);
        import branch_pkg::*;

        ctrl_state_t state;
        logic        target_wrong;
        logic        dir_wrong;
        logic        miss;

        // kick both evaluators as the request is seen
        assign o_start = (state == ST_IDLE) && i_req;

        // --------------------
        // misprediction check
        // taken branch whose stored target was stale or missing
        assign target_wrong = i_taken && (i_pred_pc != i_actual_pc);
        // predicted taken but fell through
        assign dir_wrong = !i_taken && (i_pred_pc != i_actual_pc);
        assign miss = i_is_branch && (target_wrong || dir_wrong);

        // --------------------
        // four-phase handshake
        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        state        <= ST_IDLE;
                        o_ack        <= 1'b0;
                        o_update     <= 1'b0;
                        o_next_pc    <= '0;
                        o_mispredict <= 1'b0;
                end else begin
                        o_update <= 1'b0;
                        case (state)
                                ST_IDLE: begin
                                        if (i_req)
                                                state <= ST_EVAL;
                                end
                                ST_EVAL: begin
                                        state        <= ST_ACK;
                                        o_next_pc    <= i_actual_pc;
                                        o_mispredict <= miss;
                                        // buffer only learns from branches
                                        o_update     <= i_is_branch;
                                end
                                ST_ACK: begin
                                        // hold results until requester lets go
                                        if (o_ack && !i_req) begin
                                                state <= ST_IDLE;
                                                o_ack <= 1'b0;
                                        end else begin
                                                o_ack <= 1'b1;
                                        end
                                end
                                default: state <= ST_IDLE;
                        endcase
                end
        end

        // --------------------
        // statistics
        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        o_num_branch <= '0;
                        o_num_miss   <= '0;
                end else if (state == ST_EVAL) begin
                        if (i_is_branch)
                                o_num_branch <= o_num_branch + 1'b1;
                        if (miss)
                                o_num_miss <= o_num_miss + 1'b1;
                end
        end

endmodule

/* verilog/branch_resolver.sv */
`timescale 1ns/1ns
`include "branch_defines.svh"

module branch_resolver (
        input  logic                  clk,
        input  logic                  reset_n,
        input  logic                  i_start,
        input  logic [`WORD_SIZE-1:0] i_pc,
        input  logic [`WORD_SIZE-1:0] i_instr,
        input  logic [`WORD_SIZE-1:0] i_op_a,
        input  logic [`WORD_SIZE-1:0] i_op_b,
        output logic                  o_is_branch,
        output logic                  o_taken,
        output logic [`WORD_SIZE-1:0] o_actual_pc
);
        import isa_pkg::*;

        opcode_t                      op;
        compare_t                     cmp;
        logic signed [`WORD_SIZE-1:0] lhs;
        logic signed [`WORD_SIZE-1:0] rhs;
        logic [IMM8_MSB:0]            imm8;
        logic [`WORD_SIZE-1:0]        pc_inc;
        logic [`WORD_SIZE-1:0]        br_target;
        logic [`WORD_SIZE-1:0]        jmp_target;
        logic                         is_branch;
        logic                         taken;

        assign op   = opcode_t'(i_instr[OPCODE_MSB:OPCODE_LSB]);
        assign imm8 = i_instr[IMM8_MSB:0];

        // --------------------
        // targets
        assign pc_inc     = i_pc + 1'b1;
        assign br_target  = pc_inc + {{(`WORD_SIZE-IMM8_MSB-1){imm8[IMM8_MSB]}}, imm8};
        assign jmp_target = {i_pc[`WORD_SIZE-1:IMM12_MSB+1], i_instr[IMM12_MSB:0]};

        // bgz and blz test against zero
        assign lhs = i_op_a;
        assign rhs = (op == BGZ || op == BLZ) ? '0 : i_op_b;
        assign cmp = (lhs > rhs) ? CMP_BIG : ((lhs == rhs) ? CMP_SAME : CMP_SMALL);

        always_comb begin
                is_branch = 1'b1;
                case (op)
                        BNE: taken = (cmp != CMP_SAME);
                        BEQ: taken = (cmp == CMP_SAME);
                        BGZ: taken = (cmp == CMP_BIG);
                        BLZ: taken = (cmp == CMP_SMALL);
                        JMP: taken = 1'b1;
                        default: begin
                                is_branch = 1'b0;
                                taken     = 1'b0;
                        end
                endcase
        end

        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        o_is_branch <= 1'b0;
                        o_taken     <= 1'b0;
                        o_actual_pc <= '0;
                end else if (i_start) begin
                        o_is_branch <= is_branch;
                        o_taken     <= taken;
                        if (!taken)
                                o_actual_pc <= pc_inc;
                        else
                                o_actual_pc <= (op == JMP) ? jmp_target : br_target;
                end
        end

endmodule

/* verilog/branch_unit.sv */
`timescale 1ns/1ns
`include "branch_defines.svh"

module branch_unit (
        input  logic                  clk,
        input  logic                  reset_n,
        input  logic                  i_req,
        input  logic [`WORD_SIZE-1:0] i_pc,
        input  logic [`WORD_SIZE-1:0] i_instr,
        input  logic [`WORD_SIZE-1:0] i_op_a,
        input  logic [`WORD_SIZE-1:0] i_op_b,
        output logic                  o_ack,
        output logic [`WORD_SIZE-1:0] o_next_pc,
        output logic                  o_mispredict,
        output logic [`WORD_SIZE-1:0] o_num_branch,
        output logic [`WORD_SIZE-1:0] o_num_miss
);

        // control to both evaluators
        logic                  start;
        logic                  update;

        // evaluator results
        logic [`WORD_SIZE-1:0] pred_pc;
        logic                  is_branch;
        logic                  taken;
        logic [`WORD_SIZE-1:0] actual_pc;

        branch_predictor u_predictor (
                .clk       (clk),
                .reset_n   (reset_n),
                .i_start   (start),
                .i_pc      (i_pc),
                .i_update  (update),
                .i_taken   (taken),
                .i_target  (actual_pc),
                .o_pred_pc (pred_pc)
        );

        branch_resolver u_resolver (
                .clk         (clk),
                .reset_n     (reset_n),
                .i_start     (start),
                .i_pc        (i_pc),
                .i_instr     (i_instr),
                .i_op_a      (i_op_a),
                .i_op_b      (i_op_b),
                .o_is_branch (is_branch),
                .o_taken     (taken),
                .o_actual_pc (actual_pc)
        );

        branch_control u_control (
                .clk          (clk),
                .reset_n      (reset_n),
                .i_req        (i_req),
                .i_pred_pc    (pred_pc),
                .i_is_branch  (is_branch),
                .i_taken      (taken),
                .i_actual_pc  (actual_pc),
                .o_start      (start),
                .o_update     (update),
                .o_ack        (o_ack),
                .o_next_pc    (o_next_pc),
                .o_mispredict (o_mispredict),
                .o_num_branch (o_num_branch),
                .o_num_miss   (o_num_miss)
        );

endmodule
